//--- hdl/pat_isa_pkg.sv
package pat_isa_pkg;

	localparam int I_WIDTH = 23; // one instruction word

	// ==================================================
	// i8 space, an even opcode takes the immediate
	localparam logic [3:0] OP_ORI  = 4'b0000;
	localparam logic [3:0] OP_ORR  = 4'b0001;
	localparam logic [3:0] OP_ANDI = 4'b0010;
	localparam logic [3:0] OP_ANDR = 4'b0011;
	localparam logic [3:0] OP_ADDI = 4'b0100;
	localparam logic [3:0] OP_ADDR = 4'b0101;
	localparam logic [3:0] OP_SUBI = 4'b0110;
	localparam logic [3:0] OP_SUBR = 4'b0111;
	localparam logic [3:0] OP_LDI  = 4'b1000;
	localparam logic [3:0] PREFIX  = 4'b1111; // escape into the next space

	// i3 space, same even/odd rule
	localparam logic [3:0] I3_SHLZI = 4'b0000;
	localparam logic [3:0] I3_SHLZR = 4'b0001;
	localparam logic [3:0] I3_SHLOI = 4'b0010;
	localparam logic [3:0] I3_SHLOR = 4'b0011;
	localparam logic [3:0] I3_SHRZI = 4'b0100;
	localparam logic [3:0] I3_SHRZR = 4'b0101;
	localparam logic [3:0] I3_SHROI = 4'b0110;
	localparam logic [3:0] I3_SHROR = 4'b0111;
	localparam logic [3:0] I3_OUT   = 4'b1011;

	// i0 space
	localparam logic [3:0] I0_NOT  = 4'b0000;
	localparam logic [3:0] I0_TEST = 4'b0010;
	localparam logic [3:0] I0_NOP  = 4'b0101;

	// condition field
	localparam logic [1:0] COND_Z  = 2'd0;
	localparam logic [1:0] COND_NZ = 2'd1;
	localparam logic [1:0] COND_N  = 2'd2;
	localparam logic [1:0] COND_AL = 2'd3;

	// ==================================================
	typedef struct packed {
		logic [2:0] rn;
		logic [4:0] fieldp;   // reserved
		logic [1:0] cond;
		logic       field_op; // reserved
		logic [3:0] opcode;
		logic [7:0] imm;
	} instr_i8_t;

	typedef struct packed {
		logic [2:0] rn;
		logic [4:0] fieldp;
		logic [1:0] cond;
		logic       field_op;
		logic [3:0] prefix;   // overlays the i8 opcode
		logic [3:0] op_i3;
		logic [3:0] low;      // i0 opcode, or imm3 in bits 2:0
	} instr_short_t;

	typedef union packed {
		instr_i8_t    i8;
		instr_short_t short_form;
	} instr_u;

endpackage

//--- hdl/pat_dp_pkg.sv
package pat_dp_pkg;

	localparam int D_WIDTH   = 8; // accumulator and register width
	localparam int REG_ADR_W = 3;
	localparam int REG_COUNT = 8;
	localparam int ALU_OP_W  = 4;

	// ==================================================
	// alu select codes
	localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_NOT    = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd5; // ldi

	// shift codes, handled by the shifter
	localparam logic [ALU_OP_W-1:0] ALU_SHLZ   = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_SHLO   = 4'd9;
	localparam logic [ALU_OP_W-1:0] ALU_SHRZ   = 4'd10;
	localparam logic [ALU_OP_W-1:0] ALU_SHRO   = 4'd11;

endpackage

//--- hdl/pat_shifter.sv
`timescale 1ns/1ps

module pat_shifter (
	input  logic [pat_dp_pkg::D_WIDTH-1:0]  i_a,
	input  logic [1:0]                      i_count,
	input  logic [pat_dp_pkg::ALU_OP_W-1:0] i_alu_op,
	output logic [pat_dp_pkg::D_WIDTH-1:0]  o_y
);
	import pat_dp_pkg::*;

	logic [2:0]         amount; // 1 to 4
	logic [D_WIDTH-1:0] shl_z;
	logic [D_WIDTH-1:0] shl_o;
	logic [D_WIDTH-1:0] shr_z;
	logic [D_WIDTH-1:0] shr_o;

	assign amount = {1'b0, i_count} + 3'd1;

	assign shl_z = i_a << amount;
	assign shr_z = i_a >> amount;
	// shifting the inverse brings in ones once inverted back
	assign shl_o = ~((~i_a) << amount);
	assign shr_o = ~((~i_a) >> amount);

	always_comb
	begin
		case (i_alu_op)
			ALU_SHLZ: o_y = shl_z;
			ALU_SHLO: o_y = shl_o;
			ALU_SHRZ: o_y = shr_z;
			ALU_SHRO: o_y = shr_o;
			default:  o_y = i_a; // not a shift, result unused
		endcase
	end

endmodule

//--- hdl/pat_alu.sv
`timescale 1ns/1ps

module pat_alu (
	input  logic [pat_dp_pkg::D_WIDTH-1:0]  i_a,
	input  logic [pat_dp_pkg::D_WIDTH-1:0]  i_b,
	input  logic [pat_dp_pkg::ALU_OP_W-1:0] i_alu_op,
	output logic [pat_dp_pkg::D_WIDTH-1:0]  o_y
);
	import pat_dp_pkg::*;

	logic [D_WIDTH-1:0] shift_y;

	// ==================================================
	// shifter, count in the low two bits of b
	pat_shifter u_shifter (
		.i_a      (i_a),
		.i_count  (i_b[1:0]),
		.i_alu_op (i_alu_op),
		.o_y      (shift_y)
	);

	// ==================================================
	// result select
	always_comb
	begin
		case (i_alu_op)
			ALU_OR:     o_y = i_a | i_b;
			ALU_AND:    o_y = i_a & i_b;
			ALU_ADD:    o_y = i_a + i_b; // wraps modulo 256
			ALU_SUB:    o_y = i_a - i_b;
			ALU_NOT:    o_y = ~i_a;
			ALU_PASS_B: o_y = i_b;
			ALU_SHLZ,
			ALU_SHLO,
			ALU_SHRZ,
			ALU_SHRO:   o_y = shift_y;
			default:    o_y = '0;
		endcase
	end

endmodule

//--- hdl/pat_reg_file.sv
`timescale 1ns/1ps

module pat_reg_file (
	input  logic                             clk,
	input  logic [pat_dp_pkg::REG_ADR_W-1:0] i_rd_adr,
	output logic [pat_dp_pkg::D_WIDTH-1:0]   o_rd_data,
	input  logic                             i_wr_en,
	input  logic [pat_dp_pkg::REG_ADR_W-1:0] i_wr_adr,
	input  logic [pat_dp_pkg::D_WIDTH-1:0]   i_wr_data
);
	import pat_dp_pkg::*;

	logic [D_WIDTH-1:0] regs [REG_COUNT];

	// ==================================================
	// read port, combinational
	// a write in the same cycle shows up only after the edge
	assign o_rd_data = regs[i_rd_adr];

	// write port
	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			regs[i_wr_adr] <= i_wr_data;
	end

	// the write address comes from the previous decode, so it must be settled
	a_wr_adr_known : assert property (@(posedge clk)
		i_wr_en |-> !$isunknown(i_wr_adr));

endmodule

//--- hdl/pat_decode.sv
`timescale 1ns/1ps

module pat_decode (
	input  logic                             clk,
	input  logic                             reset,
	input  pat_isa_pkg::instr_u              i_instr,
	output logic [pat_dp_pkg::REG_ADR_W-1:0] o_rd_adr,
	input  logic [pat_dp_pkg::D_WIDTH-1:0]   i_rd_data,
	input  logic                             i_fwd_valid,
	input  logic [pat_dp_pkg::REG_ADR_W-1:0] i_fwd_adr,
	input  logic [pat_dp_pkg::D_WIDTH-1:0]   i_fwd_data,
	output logic [pat_dp_pkg::ALU_OP_W-1:0]  o_alu_op,
	output logic                             o_a_is_acc,
	output logic [pat_dp_pkg::D_WIDTH-1:0]   o_operand_b,
	output logic [pat_dp_pkg::D_WIDTH-1:0]   o_reg_value,
	output logic [pat_dp_pkg::REG_ADR_W-1:0] o_rn,
	output logic [1:0]                       o_cond,
	output logic                             o_write_reg,
	output logic                             o_is_test,
	output logic                             o_is_out
);
	import pat_isa_pkg::*;
	import pat_dp_pkg::*;

	logic                is_i8;
	logic                is_i3; // i0 is whatever sits behind both prefixes
	logic [D_WIDTH-1:0]  reg_value;
	logic [D_WIDTH-1:0]  imm3_ext;
	logic [ALU_OP_W-1:0] alu_op_d;
	logic                a_is_acc_d;
	logic [D_WIDTH-1:0]  operand_b_d;
	logic                write_reg_d;
	logic                is_test_d;
	logic                is_out_d;

	// ==================================================
	// class and register read
	assign is_i8 = (i_instr.i8.opcode != PREFIX);
	assign is_i3 = (i_instr.short_form.prefix == PREFIX) && (i_instr.short_form.op_i3 != PREFIX);

	assign o_rd_adr  = i_instr.i8.rn;
	// execute commits its result at the same edge, so take it from the bypass
	assign reg_value = (i_fwd_valid && (i_fwd_adr == i_instr.i8.rn)) ? i_fwd_data : i_rd_data;
	assign imm3_ext  = {{(D_WIDTH-3){1'b0}}, i_instr.short_form.low[2:0]};

	always_comb
	begin
		alu_op_d    = ALU_OR;
		a_is_acc_d  = 1'b0;
		operand_b_d = reg_value;
		write_reg_d = 1'b0;
		is_test_d   = 1'b0;
		is_out_d    = 1'b0;
		if (is_i8)
		begin
			case (i_instr.i8.opcode)
				OP_ORI, OP_ORR:   alu_op_d = ALU_OR;
				OP_ANDI, OP_ANDR: alu_op_d = ALU_AND;
				OP_ADDI, OP_ADDR: alu_op_d = ALU_ADD;
				OP_SUBI, OP_SUBR: alu_op_d = ALU_SUB;
				default:          alu_op_d = ALU_PASS_B;
			endcase
			write_reg_d = !i_instr.i8.opcode[3] || (i_instr.i8.opcode == OP_LDI);
			if (i_instr.i8.opcode[0])
				a_is_acc_d = 1'b1; // acc op R[rn]
			else
				operand_b_d = i_instr.i8.imm; // R[rn] op imm8
		end
		else if (is_i3)
		begin
			case (i_instr.short_form.op_i3)
				I3_SHLZI, I3_SHLZR: alu_op_d = ALU_SHLZ;
				I3_SHLOI, I3_SHLOR: alu_op_d = ALU_SHLO;
				I3_SHRZI, I3_SHRZR: alu_op_d = ALU_SHRZ;
				I3_SHROI, I3_SHROR: alu_op_d = ALU_SHRO;
				default:            alu_op_d = ALU_PASS_B;
			endcase
			write_reg_d = !i_instr.short_form.op_i3[3];
			is_out_d    = (i_instr.short_form.op_i3 == I3_OUT);
			if (i_instr.short_form.op_i3[0])
				a_is_acc_d = 1'b1; // shift count from R[rn]
			else
				operand_b_d = imm3_ext;
		end
		else
		begin
			case (i_instr.short_form.low)
				I0_NOT:
				begin
					alu_op_d    = ALU_NOT;
					write_reg_d = 1'b1;
				end
				I0_TEST: is_test_d = 1'b1;
				I0_NOP:  write_reg_d = 1'b0;
				default: write_reg_d = 1'b0; // unknown i0 acts as nop
			endcase
		end
	end

	// ==================================================
	// stage register
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_alu_op    <= ALU_OR;
			o_a_is_acc  <= 1'b0;
			o_cond      <= COND_AL;
			o_write_reg <= 1'b0;
			o_is_test   <= 1'b0;
			o_is_out    <= 1'b0;
		end
		else
		begin
			o_alu_op    <= alu_op_d;
			o_a_is_acc  <= a_is_acc_d;
			o_cond      <= i_instr.i8.cond;
			o_write_reg <= write_reg_d;
			o_is_test   <= is_test_d;
			o_is_out    <= is_out_d;
		end
		o_operand_b <= operand_b_d;
		o_reg_value <= reg_value;
		o_rn        <= i_instr.i8.rn;
	end

	// execute sees at most one kind of commit per instruction
	a_one_class : assert property (@(posedge clk) disable iff (reset)
		$onehot0({o_write_reg, o_is_test, o_is_out}));

endmodule

//--- hdl/pat_execute.sv
`timescale 1ns/1ps

module pat_execute (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [pat_dp_pkg::ALU_OP_W-1:0]  i_alu_op,
	input  logic                             i_a_is_acc,
	input  logic [pat_dp_pkg::D_WIDTH-1:0]   i_operand_b,
	input  logic [pat_dp_pkg::D_WIDTH-1:0]   i_reg_value,
	input  logic [pat_dp_pkg::REG_ADR_W-1:0] i_rn,
	input  logic [1:0]                       i_cond,
	input  logic                             i_write_reg,
	input  logic                             i_is_test,
	input  logic                             i_is_out,
	output logic                             o_wr_en,
	output logic [pat_dp_pkg::REG_ADR_W-1:0] o_wr_adr,
	output logic [pat_dp_pkg::D_WIDTH-1:0]   o_wr_data,
	output logic                             o_fwd_valid,
	output logic [pat_dp_pkg::REG_ADR_W-1:0] o_fwd_adr,
	output logic [pat_dp_pkg::D_WIDTH-1:0]   o_fwd_data,
	output logic [pat_dp_pkg::D_WIDTH-1:0]   o_out_data,
	output logic                             o_out_strobe
);
	import pat_isa_pkg::*;
	import pat_dp_pkg::*;

	logic [D_WIDTH-1:0] acc;
	logic               flag_z;
	logic               flag_n;
	logic               cond_ok;
	logic               test_go;
	logic               out_go;
	logic [D_WIDTH-1:0] alu_a;
	logic [D_WIDTH-1:0] alu_y;

	// ==================================================
	// condition against flags left by earlier instructions
	always_comb
	begin
		case (i_cond)
			COND_Z:  cond_ok = flag_z;
			COND_NZ: cond_ok = !flag_z;
			COND_N:  cond_ok = flag_n;
			default: cond_ok = 1'b1; // always
		endcase
	end

	assign test_go = cond_ok && i_is_test;
	assign out_go  = cond_ok && i_is_out;

	// ==================================================
	// alu
	assign alu_a = i_a_is_acc ? acc : i_reg_value;

	pat_alu u_alu (
		.i_a      (alu_a),
		.i_b      (i_operand_b),
		.i_alu_op (i_alu_op),
		.o_y      (alu_y)
	);

	// register write lands on the commit edge while decode bypasses it
	assign o_wr_en     = cond_ok && i_write_reg;
	assign o_wr_adr    = i_rn;
	assign o_wr_data   = alu_y;
	assign o_fwd_valid = o_wr_en;
	assign o_fwd_adr   = i_rn;
	assign o_fwd_data  = alu_y;

	// ==================================================
	// commit
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc          <= '0;
			flag_z       <= 1'b0;
			flag_n       <= 1'b0;
			o_out_data   <= '0;
			o_out_strobe <= 1'b0;
		end
		else
		begin
			o_out_strobe <= out_go; // one cycle per out
			if (o_wr_en)
				acc <= alu_y;
			if (test_go)
			begin
				flag_z <= (i_reg_value == '0);
				flag_n <= i_reg_value[D_WIDTH-1];
			end
			if (out_go)
				o_out_data <= acc;
		end
	end

	// back to back strobes repeat the value since out never writes the accumulator
	a_strobe_pulse : assert property (@(posedge clk) disable iff (reset)
		(o_out_strobe && $past(o_out_strobe)) |-> $stable(o_out_data));

endmodule

//--- hdl/pat_core.sv
`timescale 1ns/1ps

module pat_core (
	input  logic                           clk,
	input  logic                           reset,
	input  pat_isa_pkg::instr_u            i_instr,
	output logic [pat_dp_pkg::D_WIDTH-1:0] o_out_data,
	output logic                           o_out_strobe
);
	import pat_dp_pkg::*;

	// register file ports
	logic [REG_ADR_W-1:0] rd_adr;
	logic [D_WIDTH-1:0]   rd_data;
	logic                 wr_en;
	logic [REG_ADR_W-1:0] wr_adr;
	logic [D_WIDTH-1:0]   wr_data;

	// bypass from execute
	logic                 fwd_valid;
	logic [REG_ADR_W-1:0] fwd_adr;
	logic [D_WIDTH-1:0]   fwd_data;

	// stage one register
	logic [ALU_OP_W-1:0]  alu_op;
	logic                 a_is_acc;
	logic [D_WIDTH-1:0]   operand_b;
	logic [D_WIDTH-1:0]   reg_value;
	logic [REG_ADR_W-1:0] rn;
	logic [1:0]           cond;
	logic                 write_reg;
	logic                 is_test;
	logic                 is_out;

	// ==================================================
	pat_decode u_decode (
		.clk         (clk),         .reset       (reset),
		.i_instr     (i_instr),     .o_rd_adr    (rd_adr),
		.i_rd_data   (rd_data),     .i_fwd_valid (fwd_valid),
		.i_fwd_adr   (fwd_adr),     .i_fwd_data  (fwd_data),
		.o_alu_op    (alu_op),      .o_a_is_acc  (a_is_acc),
		.o_operand_b (operand_b),   .o_reg_value (reg_value),
		.o_rn        (rn),          .o_cond      (cond),
		.o_write_reg (write_reg),   .o_is_test   (is_test),
		.o_is_out    (is_out)
	);

	pat_reg_file u_reg_file (
		.clk       (clk),     .i_rd_adr  (rd_adr),
		.o_rd_data (rd_data), .i_wr_en   (wr_en),
		.i_wr_adr  (wr_adr),  .i_wr_data (wr_data)
	);

	pat_execute u_execute (
		.clk          (clk),          .reset        (reset),
		.i_alu_op     (alu_op),       .i_a_is_acc   (a_is_acc),
		.i_operand_b  (operand_b),    .i_reg_value  (reg_value),
		.i_rn         (rn),           .i_cond       (cond),
		.i_write_reg  (write_reg),    .i_is_test    (is_test),
		.i_is_out     (is_out),       .o_wr_en      (wr_en),
		.o_wr_adr     (wr_adr),       .o_wr_data    (wr_data),
		.o_fwd_valid  (fwd_valid),    .o_fwd_adr    (fwd_adr),
		.o_fwd_data   (fwd_data),     .o_out_data   (o_out_data),
		.o_out_strobe (o_out_strobe)
	);

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0; // released just after the second rising edge
	end

endmodule

//--- verif/tb_pat_core.sv
`timescale 1ns/1ps

module tb_pat_core;
	import pat_isa_pkg::*;

	localparam int N_RANDOM = 400;

	logic               clk;
	logic               reset;
	logic [I_WIDTH-1:0] instr;
	logic [7:0]         out_data;
	logic               out_strobe;
	integer             seed;
	int                 errors;
	int                 strobes;
	int                 cycles;
	int                 cycle_limit;
	logic               out_issued; // no strobe may show before this
	logic [7:0]         m_acc;      // model state
	logic               m_z;
	logic               m_n;
	logic [7:0]         m_regs [8];
	logic [I_WIDTH-1:0] prog_q [$];
	logic [7:0]         exp_q [$];
	string              name_q [$];
	int                 slot_q [$]; // check slot where each strobe is due

	tb_clock u_clock (.clk(clk), .reset(reset));

	pat_core uut (
		.clk          (clk),
		.reset        (reset),
		.i_instr      (instr),
		.o_out_data   (out_data),
		.o_out_strobe (out_strobe)
	);

	// ==================================================
	// program building and reference model
	function automatic logic [31:0] rand32();
		rand32 = $random(seed);
	endfunction

	function automatic logic [I_WIDTH-1:0] enc(input logic [2:0] rn, input logic [1:0] c,
		input logic [3:0] op, input logic [7:0] low);
		enc = {rn, 5'd0, c, 1'b0, op, low};
	endfunction

	function automatic logic cond_holds(input logic [1:0] c);
		case (c)
			COND_Z:  cond_holds = m_z;
			COND_NZ: cond_holds = !m_z;
			COND_N:  cond_holds = m_n;
			default: cond_holds = 1'b1;
		endcase
	endfunction

	// one place at a time for count field plus one steps
	function automatic logic [7:0] shift_model(input logic [7:0] v, input logic [1:0] cnt,
		input logic right, input logic fill);
		logic [7:0] s;
		logic [2:0] n;
		s = v;
		n = {1'b0, cnt} + 3'd1;
		repeat (n)
			s = right ? {fill, s[7:1]} : {s[6:0], fill};
		shift_model = s;
	endfunction

	// append one instruction to the program and step the model over it
	task automatic emit(input logic [I_WIDTH-1:0] w_in, input string name);
		logic [I_WIDTH-1:0] w;
		logic [31:0]        r;
		logic [7:0]         rv;
		logic [7:0]         a;
		logic [7:0]         b;
		logic [7:0]         res;
		logic               wr;
		begin
			r        = rand32();
			w        = w_in;
			w[19:15] = r[4:0]; // reserved fields must be ignored
			w[12]    = r[5];
			prog_q.push_back(w);
			rv  = m_regs[w[22:20]];
			a   = w[8] ? m_acc : rv; // odd i8 opcode is the register form
			b   = w[8] ? rv : w[7:0];
			res = 8'h00;
			wr  = 1'b0;
			if (cond_holds(w[14:13]))
			begin
				wr = 1'b1;
				case (w[11:8])
					OP_ORI, OP_ORR:   res = a | b;
					OP_ANDI, OP_ANDR: res = a & b;
					OP_ADDI, OP_ADDR: res = a + b;
					OP_SUBI, OP_SUBR: res = a - b;
					OP_LDI:           res = w[7:0];
					default:          wr = 1'b0; // prefix and dropped opcodes
				endcase
				if (w[11:8] == PREFIX && w[7:4] <= I3_SHROR)
				begin
					wr  = 1'b1;
					res = w[4] ? shift_model(m_acc, rv[1:0], w[6], w[5])
						: shift_model(rv, w[1:0], w[6], w[5]);
				end
				if (w[11:4] == {PREFIX, I3_OUT})
				begin
					exp_q.push_back(m_acc);
					name_q.push_back(name);
					slot_q.push_back(prog_q.size() + 1); // decode edge, then commit edge
				end
				if (w[11:0] == {PREFIX, PREFIX, I0_NOT})
				begin
					wr  = 1'b1;
					res = ~rv;
				end
				if (w[11:0] == {PREFIX, PREFIX, I0_TEST})
				begin
					m_z = (rv == 8'h00);
					m_n = rv[7];
				end
			end
			if (wr)
			begin
				m_acc            = res;
				m_regs[w[22:20]] = res;
			end
		end
	endtask

	task automatic random_instr();
		logic [31:0]        r;
		logic [2:0]         rn;
		logic [1:0]         c;
		logic [3:0]         hi; // upper half of an opcode space
		logic [I_WIDTH-1:0] w;
		begin
			r  = rand32();
			rn = r[10:8];
			c  = r[12] ? COND_AL : r[14:13];
			hi = {1'b1, r[6:4]};
			case (r[3:0])
				4'd6:    w = enc(rn, c, OP_LDI, r[23:16]);
				4'd7, 4'd8, 4'd9:
					w = enc(rn, c, PREFIX, {1'b0, r[6:4], r[19:16]}); // shifts
				4'd10:   w = enc(rn, c, PREFIX, {PREFIX, I0_NOT});
				4'd11:   w = enc(rn, c, PREFIX, {PREFIX, I0_TEST});
				4'd12:   w = enc(rn, c, PREFIX, {PREFIX, I0_NOP});
				// dropped and unknown opcodes in all three spaces
				4'd13:   w = enc(rn, c, (hi == OP_LDI || hi == PREFIX) ? 4'b1001 : hi, r[23:16]);
				4'd14:   w = enc(rn, c, PREFIX,
						{(hi == I3_OUT || hi == PREFIX) ? 4'b1000 : hi, r[19:16]});
				4'd15:   w = enc(rn, c, PREFIX, {PREFIX, hi});
				default: w = enc(rn, c, {1'b0, r[6:4]}, r[23:16]); // or, and, add, sub
			endcase
			emit(w, "random");
		end
	endtask

	// ==================================================
	// output checks on the falling edge where outputs are settled
	task automatic check_outputs(input int slot);
		logic [7:0] exp;
		string      name;
		int         due;
		begin
			if (!out_issued && (out_strobe !== 1'b0 || out_data !== 8'h00))
			begin
				errors++;
				$display("output port active before any out instruction");
			end
			if (out_strobe === 1'b1)
			begin
				strobes++;
				if (exp_q.size() == 0)
				begin
					errors++;
					$display("strobe seen with no out instruction left to match it");
				end
				else
				begin
					exp  = exp_q.pop_front();
					name = name_q.pop_front();
					due  = slot_q.pop_front();
					if (due != slot)
					begin
						errors++;
						$display("strobe for %s came at slot %0d instead of slot %0d",
							name, slot, due);
					end
					if (out_data !== exp)
					begin
						errors++;
						$display("Fail %s: expected %h, actual %h", name, exp, out_data);
					end
				end
			end
			else if (out_strobe !== 1'b0)
			begin
				errors++;
				$display("output strobe is unknown");
			end
			else if (slot_q.size() != 0 && slot_q[0] == slot)
			begin
				exp  = exp_q.pop_front();
				name = name_q.pop_front();
				due  = slot_q.pop_front();
				errors++;
				$display("no strobe for %s at slot %0d", name, due);
			end
		end
	endtask

	initial
	begin
		logic [31:0] r;
		seed       = 32'h63ee;
		errors     = 0;
		strobes    = 0;
		cycles     = 0;
		out_issued = 1'b0;
		m_acc      = 8'h00;
		m_z        = 1'b0;
		m_n        = 1'b0;
		instr      = enc(3'd0, COND_AL, PREFIX, {PREFIX, I0_NOP});
		for (int k = 0; k < 8; k++)
		begin
			r = rand32();
			emit(enc(k[2:0], COND_AL, OP_LDI, r[7:0]), "init");
		end
		// load, bypass into the very next read, then show it
		emit(enc(3'd3, COND_AL, OP_LDI, 8'ha5), "ldi_fwd");
		emit(enc(3'd3, COND_AL, OP_ORI, 8'h00), "ldi_fwd");
		emit(enc(3'd0, COND_AL, PREFIX, {I3_OUT, 4'h0}), "ldi_fwd");
		// flags from test, then each condition
		emit(enc(3'd1, COND_AL, OP_LDI, 8'h00), "cond");
		emit(enc(3'd1, COND_AL, PREFIX, {PREFIX, I0_TEST}), "cond");
		emit(enc(3'd5, COND_NZ, OP_LDI, 8'h3c), "cond");
		emit(enc(3'd0, COND_Z, PREFIX, {I3_OUT, 4'h0}), "cond");
		emit(enc(3'd0, COND_NZ, PREFIX, {I3_OUT, 4'h0}), "cond");
		emit(enc(3'd2, COND_AL, OP_LDI, 8'h80), "cond");
		emit(enc(3'd2, COND_AL, PREFIX, {PREFIX, I0_TEST}), "cond");
		emit(enc(3'd0, COND_N, PREFIX, {I3_OUT, 4'h0}), "cond");
		emit(enc(3'd0, COND_Z, PREFIX, {I3_OUT, 4'h0}), "cond");
		for (int k = 0; k < N_RANDOM; k++)
		begin
			random_instr();
			r = rand32();
			if (r[1:0] == 2'b00) // an out about every fourth slot
				emit(enc(3'd0, r[2] ? COND_AL : r[4:3], PREFIX, {I3_OUT, 4'h0}), "random");
		end
		repeat (4)
			emit(enc(3'd0, COND_AL, PREFIX, {PREFIX, I0_NOP}), "tail");
		cycle_limit = prog_q.size() + 20;

		@(negedge clk);
		while (reset)
			@(negedge clk);
		foreach (prog_q[k])
		begin
			check_outputs(k);
			instr = prog_q[k];
			if (prog_q[k][11:4] == {PREFIX, I3_OUT})
				out_issued = 1'b1;
			@(negedge clk);
		end
		check_outputs(prog_q.size());
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("%0d out results were expected but never strobed", exp_q.size());
		end
		$display("errors %0d, strobes %0d, instructions %0d", errors, strobes, prog_q.size());
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// run length limit counted from the end of reset
	always @(posedge clk)
	begin
		if (!reset)
			cycles++;
		if (cycles > cycle_limit)
		begin
			$display("timeout, run went past %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

endmodule

//--- list.f
hdl/pat_isa_pkg.sv
hdl/pat_dp_pkg.sv
hdl/pat_shifter.sv
hdl/pat_alu.sv
hdl/pat_reg_file.sv
hdl/pat_decode.sv
hdl/pat_execute.sv
hdl/pat_core.sv
verif/tb_clock.sv
verif/tb_pat_core.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_pat_core -f list.f -o tb_pat_core \
	&& ./obj_dir/tb_pat_core | tee sim.log
grep -qx '=== PASS ===' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
